// File: src/memSysPkg.sv
// Memory system shared definitions
`default_nettype none

package memSysPkg;

    localparam int AddrW = 16;
    localparam int DataW = 16;
    localparam int TagW = 5;            // Address bits 15:11
    localparam int IndexW = 8;          // Address bits 10:3
    localparam int Lines = 256;
    localparam int WordsPerLine = 4;    // Address bits 2:1
    localparam int WordSelW = $clog2(WordsPerLine);
    localparam int OffsetW = WordSelW + 1;

    localparam int NumBanks = 4;
    localparam int BankW = $clog2(NumBanks);
    localparam int BankBusyCycles = 4;
    localparam int BusyCntW = $clog2(BankBusyCycles + 1);
    localparam int MemReadLatency = 2;
    localparam int MemWords = 2 ** (AddrW - 1);  // One word per even byte address

    // Request from the outside, held until done
    typedef struct packed {
        logic             rd;
        logic             wr;
        logic [AddrW-1:0] addr;
        logic [DataW-1:0] data;
    } memReq_t;

    // Broadcast to both ways
    typedef struct packed {
        logic [TagW-1:0]    tag;
        logic [IndexW-1:0]  index;
        logic [OffsetW-1:0] offset;
        logic [DataW-1:0]   data;
        logic               comp;
        logic               write;
        logic               validIn;
    } wayCmd_t;

    typedef struct packed {
        logic             hit;
        logic             valid;
        logic             dirty;
        logic [TagW-1:0]  tagOut;
        logic [DataW-1:0] dataOut;
    } wayStatus_t;

    typedef struct packed {
        logic             rd;
        logic             wr;
        logic [AddrW-1:0] addr;
        logic [DataW-1:0] data;
    } memCmd_t;

endpackage

`default_nettype wire

// File: src/cacheWay.sv
// Cache way storage
`default_nettype none

module cacheWay (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  enable,
    input  memSysPkg::wayCmd_t    cmd,
    output memSysPkg::wayStatus_t status
);
    import memSysPkg::*;

    logic [TagW-1:0]     tagArr [Lines];
    logic [DataW-1:0]    dataArr [Lines][WordsPerLine];
    logic [Lines-1:0]    validArr;
    logic [Lines-1:0]    dirtyArr;
    logic [WordSelW-1:0] word;
    logic                tagMatch;
    logic                compWrite;
    logic                fillWrite;

    assign word = cmd.offset[OffsetW-1:1];  // Bit 0 is the byte within a word
    assign tagMatch = tagArr[cmd.index] == cmd.tag;

    // Lookup is purely combinational
    always_comb begin
        status.hit = enable & cmd.comp & validArr[cmd.index] & tagMatch;
        status.valid = validArr[cmd.index];
        status.dirty = dirtyArr[cmd.index];
        status.tagOut = tagArr[cmd.index];
        status.dataOut = dataArr[cmd.index][word];
    end

    assign compWrite = enable & cmd.comp & cmd.write & status.hit;
    assign fillWrite = enable & ~cmd.comp & cmd.write;

    always_ff @(posedge clk) begin
        if (compWrite || fillWrite) begin
            dataArr[cmd.index][word] <= cmd.data;
        end
        if (fillWrite) begin
            tagArr[cmd.index] <= cmd.tag;   // Line takes the new owner
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validArr <= '0;
            dirtyArr <= '0;
        end else if (compWrite) begin
            dirtyArr[cmd.index] <= 1'b1;
        end else if (fillWrite) begin
            validArr[cmd.index] <= cmd.validIn;
            dirtyArr[cmd.index] <= 1'b0;    // Fresh from memory
        end
    end

    // Every fill installs a valid line
    assert property (@(posedge clk) disable iff (!rstN) fillWrite |-> cmd.validIn);

endmodule

`default_nettype wire

// File: src/bankedMem.sv
// Four bank main memory
`default_nettype none

module bankedMem (
    input  logic                           clk,
    input  logic                           rstN,
    input  memSysPkg::memCmd_t             cmd,
    output logic [memSysPkg::DataW-1:0]    data,
    output logic                           memStall,
    output logic [memSysPkg::NumBanks-1:0] bankBusy
);
    import memSysPkg::*;

    logic [DataW-1:0]    memArr [MemWords] = '{default: '0};
    logic [BusyCntW-1:0] busyCnt [NumBanks];
    logic [DataW-1:0]    rdPipe [MemReadLatency];
    logic [BankW-1:0]    bank;
    logic [AddrW-2:0]    wordAddr;
    logic                request;
    logic                accept;

    // Banks interleave on consecutive words
    assign bank = cmd.addr[BankW:1];
    assign wordAddr = cmd.addr[AddrW-1:1];
    assign request = cmd.rd | cmd.wr;

    always_comb begin
        for (int b = 0; b < NumBanks; b++) begin
            bankBusy[b] = busyCnt[b] != '0;
        end
    end

    assign memStall = request & bankBusy[bank];
    assign accept = request & ~bankBusy[bank];    // A stalled command is dropped
    assign data = rdPipe[MemReadLatency-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int b = 0; b < NumBanks; b++) begin
                busyCnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NumBanks; b++) begin
                if (accept && bank == BankW'(b)) begin
                    busyCnt[b] <= BusyCntW'(BankBusyCycles);
                end else if (busyCnt[b] != '0) begin
                    busyCnt[b] <= busyCnt[b] - 1'b1;
                end
            end
        end
    end

    // Storage and read data pipe
    always_ff @(posedge clk) begin
        if (accept && cmd.wr) begin
            memArr[wordAddr] <= cmd.data;
        end
        if (accept && cmd.rd) begin
            rdPipe[0] <= memArr[wordAddr];
        end
        for (int s = 1; s < MemReadLatency; s++) begin
            rdPipe[s] <= rdPipe[s-1];
        end
    end

    // Read and write together has no meaning for a bank
    assert property (@(posedge clk) disable iff (!rstN) cmd.rd |-> !cmd.wr);

endmodule

`default_nettype wire

// File: src/cacheCtrl.sv
// Cache controller FSM
`default_nettype none

module cacheCtrl (
    input  logic                           clk,
    input  logic                           rstN,
    input  memSysPkg::memReq_t             req,
    output memSysPkg::wayCmd_t             wayCmd,
    output logic [1:0]                     wayEn,
    input  memSysPkg::wayStatus_t          way0Status,
    input  memSysPkg::wayStatus_t          way1Status,
    output memSysPkg::memCmd_t             memCmd,
    input  logic [memSysPkg::DataW-1:0]    memData,
    input  logic                           memStall,
    input  logic [memSysPkg::NumBanks-1:0] bankBusy,
    output logic [memSysPkg::DataW-1:0]    dataOut,
    output logic                           done,
    output logic                           stall,
    output logic                           cacheHit
);
    import memSysPkg::*;

    // One-hot encoding
    typedef enum logic [12:0] {
        sIdle     = 13'd1,
        sCompare  = 13'd2,
        sAlloc0   = 13'd4,
        sAlloc1   = 13'd8,
        sAlloc2   = 13'd16,
        sAlloc3   = 13'd32,
        sAlloc4   = 13'd64,
        sAlloc5   = 13'd128,
        sWb0      = 13'd256,
        sWb1      = 13'd512,
        sWb2      = 13'd1024,
        sWb3      = 13'd2048,
        sBankWait = 13'd4096
    } state_t;

    state_t             state;
    state_t             nextState;
    memReq_t            reqQ;
    logic               waySel;         // Way being filled or written back
    logic               missQ;
    logic               victimBit;
    logic               victimWay;
    logic               hitAny;
    logic               accept;
    logic               inCompare;
    logic               fillWrite;
    logic [TagW-1:0]    reqTag;
    logic [IndexW-1:0]  reqIndex;
    logic [OffsetW-1:0] memOffset;
    logic [OffsetW-1:0] cacheOffset;
    wayStatus_t         vicStatus;
    wayStatus_t         selStatus;
    wayStatus_t         hitStatus;

    assign reqTag = reqQ.addr[AddrW-1 -: TagW];
    assign reqIndex = reqQ.addr[OffsetW +: IndexW];
    assign inCompare = state == sCompare;
    assign accept = (state == sIdle) & (req.rd | req.wr);
    assign hitAny = way0Status.hit | way1Status.hit;

    // Invalid ways first, then the toggling bit
    assign victimWay = !way0Status.valid ? 1'b0 :
                       !way1Status.valid ? 1'b1 : victimBit;
    assign vicStatus = victimWay ? way1Status : way0Status;
    assign selStatus = waySel ? way1Status : way0Status;
    assign hitStatus = way1Status.hit ? way1Status : way0Status;

    always_comb begin
        nextState = state;
        case (state)
            sIdle:     if (req.rd || req.wr) nextState = sCompare;
            sCompare: begin
                if (hitAny) begin
                    nextState = sIdle;
                end else if (vicStatus.valid && vicStatus.dirty) begin
                    nextState = sWb0;
                end else begin
                    nextState = sAlloc0;
                end
            end
            sAlloc0:   if (!memStall) nextState = sAlloc1;
            sAlloc1:   nextState = sAlloc2;
            sAlloc2:   nextState = sAlloc3;
            sAlloc3:   nextState = sAlloc4;
            sAlloc4:   nextState = sAlloc5;
            sAlloc5:   nextState = sCompare;    // Retry, now a hit
            sWb0:      if (!memStall) nextState = sWb1;
            sWb1:      if (!memStall) nextState = sWb2;
            sWb2:      if (!memStall) nextState = sWb3;
            sWb3:      if (!memStall) nextState = sBankWait;
            sBankWait: if (bankBusy == '0) nextState = sAlloc0;
            default:   nextState = sIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
            waySel <= 1'b0;
            missQ <= 1'b0;
            victimBit <= 1'b0;
        end else begin
            state <= nextState;
            if (accept) begin
                victimBit <= ~victimBit;
                missQ <= 1'b0;
            end
            if (inCompare && !hitAny) begin
                missQ <= 1'b1;
                waySel <= victimWay;    // Locked for the whole refill
            end
        end
    end

    // Request sampled every idle cycle
    always_ff @(posedge clk) begin
        if (state == sIdle) begin
            reqQ <= req;
        end
    end

    // Memory side walks words 0..3, the cache fill trails by two
    always_comb begin
        case (state)
            sAlloc1, sWb1: memOffset = 3'd2;
            sAlloc2, sWb2: memOffset = 3'd4;
            sAlloc3, sWb3: memOffset = 3'd6;
            default:       memOffset = 3'd0;
        endcase
        case (state)
            sCompare:      cacheOffset = reqQ.addr[OffsetW-1:0];
            sAlloc3, sWb1: cacheOffset = 3'd2;
            sAlloc4, sWb2: cacheOffset = 3'd4;
            sAlloc5, sWb3: cacheOffset = 3'd6;
            default:       cacheOffset = 3'd0;
        endcase
    end

    assign fillWrite = state inside {sAlloc2, sAlloc3, sAlloc4, sAlloc5};

    always_comb begin
        wayCmd.tag = reqTag;
        wayCmd.index = reqIndex;
        wayCmd.offset = cacheOffset;
        wayCmd.data = fillWrite ? memData : reqQ.data;
        wayCmd.comp = inCompare;
        wayCmd.write = fillWrite | (inCompare & reqQ.wr);
        wayCmd.validIn = fillWrite;
    end

    // Lookups go to both ways
    assign wayEn = (state inside {sIdle, sCompare}) ? 2'b11 : {waySel, ~waySel};

    always_comb begin
        memCmd.rd = state inside {sAlloc0, sAlloc1, sAlloc2, sAlloc3};
        memCmd.wr = state inside {sWb0, sWb1, sWb2, sWb3};
        memCmd.addr = {memCmd.wr ? selStatus.tagOut : reqTag, reqIndex, memOffset};
        memCmd.data = selStatus.dataOut;     // Victim word on writeback
    end

    assign done = inCompare & hitAny;
    assign cacheHit = done & ~missQ;
    assign dataOut = hitStatus.dataOut;
    assign stall = (~(state == sIdle) & ~done) | accept;

    // Stalled command held until the bank takes it
    assert property (@(posedge clk) disable iff (!rstN) memStall |=> $stable(memCmd));

    // A tag never lives in both ways
    assert property (@(posedge clk) disable iff (!rstN)
        inCompare |-> !(way0Status.hit && way1Status.hit));

endmodule

`default_nettype wire

// File: src/memSystem.sv
// Two way cache memory system
`default_nettype none

module memSystem (
    input  logic                        clk,
    input  logic                        rstN,
    input  memSysPkg::memReq_t          req,
    output logic [memSysPkg::DataW-1:0] dataOut,
    output logic                        done,
    output logic                        stall,
    output logic                        cacheHit
);
    import memSysPkg::*;

    wayCmd_t              wayCmd;
    logic [1:0]           wayEn;
    wayStatus_t           way0Status;
    wayStatus_t           way1Status;
    memCmd_t              memCmd;
    logic [DataW-1:0]     memData;
    logic                 memStall;
    logic [NumBanks-1:0]  bankBusy;

    cacheCtrl u_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .req        (req),
        .wayCmd     (wayCmd),
        .wayEn      (wayEn),
        .way0Status (way0Status),
        .way1Status (way1Status),
        .memCmd     (memCmd),
        .memData    (memData),
        .memStall   (memStall),
        .bankBusy   (bankBusy),
        .dataOut    (dataOut),
        .done       (done),
        .stall      (stall),
        .cacheHit   (cacheHit)
    );

    // Both ways see the same command
    cacheWay u_way0 (
        .clk    (clk),
        .rstN   (rstN),
        .enable (wayEn[0]),
        .cmd    (wayCmd),
        .status (way0Status)
    );

    cacheWay u_way1 (
        .clk    (clk),
        .rstN   (rstN),
        .enable (wayEn[1]),
        .cmd    (wayCmd),
        .status (way1Status)
    );

    bankedMem u_mem (
        .clk      (clk),
        .rstN     (rstN),
        .cmd      (memCmd),
        .data     (memData),
        .memStall (memStall),
        .bankBusy (bankBusy)
    );

endmodule

`default_nettype wire

// File: verification/clkGen.sv
// Testbench clock and reset
`default_nettype none

module clkGen (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    // Low for five rising edges, released just after the fifth
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/memSystemTb.sv
// Cache memory system testbench
`default_nettype none

module memSystemTb;
    timeunit 1ns;
    timeprecision 100ps;
    import memSysPkg::*;

    typedef struct {
        string   name;
        memReq_t req;
    } entry_t;

    logic             clk;
    logic             rstN;
    memReq_t          req;
    logic [DataW-1:0] dataOut;
    logic             done;
    logic             stall;
    logic             cacheHit;

    entry_t           stimTable [$];
    int               tableLen = 0;
    logic [DataW-1:0] refMem [MemWords] = '{default: '0};    // Latest value of every word
    logic [TagW-1:0]  refTag [2][Lines];
    logic             refValid [2][Lines] = '{default: '{default: 1'b0}};
    logic             refDirty [2][Lines] = '{default: '{default: 1'b0}};
    logic             refVictim = 1'b0;

    clkGen u_clk (.clk(clk), .rstN(rstN));

    memSystem u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .req      (req),
        .dataOut  (dataOut),
        .done     (done),
        .stall    (stall),
        .cacheHit (cacheHit)
    );

    // Address 15:11 tag, 10:3 index, 2:1 word
    function automatic logic [AddrW-1:0] makeAddr(int tag, int index, int word);
        return {TagW'(tag), IndexW'(index), WordSelW'(word), 1'b0};
    endfunction

    function automatic void addEntry(string name, logic wr, logic [AddrW-1:0] addr,
                                     logic [DataW-1:0] data);
        entry_t e;
        e.name = name;
        e.req = '{rd: !wr, wr: wr, addr: addr, data: data};
        stimTable.push_back(e);
    endfunction

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Check failed in %s", name);
        end
    endtask

    task automatic buildTable();
        int wr;
        // Cold miss, hit on the same word, then the rest of the line
        addEntry("cold read", 1'b0, makeAddr(1, 5, 0), '0);
        addEntry("repeat read", 1'b0, makeAddr(1, 5, 0), '0);
        addEntry("write hit", 1'b1, makeAddr(1, 5, 1), 16'hbeef);
        addEntry("write read back", 1'b0, makeAddr(1, 5, 1), '0);
        addEntry("neighbour word", 1'b0, makeAddr(1, 5, 2), '0);
        // Three tags on index 5
        addEntry("second tag", 1'b0, makeAddr(2, 5, 0), '0);
        addEntry("first tag resident", 1'b0, makeAddr(1, 5, 3), '0);
        addEntry("second tag resident", 1'b0, makeAddr(2, 5, 3), '0);
        addEntry("third tag", 1'b0, makeAddr(3, 5, 0), '0);
        addEntry("evicted tag", 1'b0, makeAddr(2, 5, 0), '0);
        addEntry("dirty line reread", 1'b0, makeAddr(1, 5, 1), '0);
        // Write miss, pushed out by two conflicting reads
        addEntry("write miss", 1'b1, makeAddr(4, 9, 3), 16'h1234);
        addEntry("conflict a", 1'b0, makeAddr(5, 9, 3), '0);
        addEntry("conflict b", 1'b0, makeAddr(6, 9, 3), '0);
        addEntry("written word reread", 1'b0, makeAddr(4, 9, 3), '0);
        for (int i = 0; i < 40; i++) begin
            wr = $urandom_range(1);
            addEntry($sformatf("random %0d", i), wr[0],
                     makeAddr(8 + $urandom_range(3), 2 + $urandom_range(1), $urandom_range(3)),
                     16'($urandom));
        end
    endtask

    // Reference cache with hit prediction, victim rule and expected data
    task automatic updateModel(input memReq_t r, output logic expHit,
                               output logic [DataW-1:0] expData, output int wbBase);
        logic [TagW-1:0]   tag;
        logic [IndexW-1:0] idx;
        int                way;
        tag = r.addr[15:11];
        idx = r.addr[10:3];
        refVictim = ~refVictim;    // Toggles on every accepted request
        way = -1;
        wbBase = -1;
        for (int w = 0; w < 2; w++) begin
            if (refValid[w][idx] && refTag[w][idx] == tag) way = w;
        end
        expHit = way >= 0;
        if (!expHit) begin
            way = !refValid[0][idx] ? 0 : !refValid[1][idx] ? 1 : int'(refVictim);
            if (refValid[way][idx] && refDirty[way][idx]) begin
                wbBase = int'({refTag[way][idx], idx, 2'b00});    // Word address of victim
            end
            refTag[way][idx] = tag;
            refValid[way][idx] = 1'b1;
            refDirty[way][idx] = 1'b0;
        end
        if (r.wr) begin
            refMem[r.addr[15:1]] = r.data;
            refDirty[way][idx] = 1'b1;
        end
        expData = refMem[r.addr[15:1]];
    endtask

    // Budget of 60 cycles per request
    initial begin
        wait (tableLen > 0);
        #(tableLen * 60 * 4);
        $display("Simulation hung, a request never completed");
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        entry_t           e;
        int               cycles;
        int               wbBase;
        logic             expHit;
        logic [DataW-1:0] expData;

        req = '0;
        void'($urandom(53749));
        buildTable();
        tableLen = stimTable.size();

        @(posedge rstN);
        #1;
        checkValue("after reset done", 0, done);
        checkValue("after reset cacheHit", 0, cacheHit);
        checkValue("after reset stall", 0, stall);

        foreach (stimTable[n]) begin
            e = stimTable[n];
            @(posedge clk);
            #1;
            checkValue({e.name, " stall while idle"}, 0, stall);
            checkValue({e.name, " done low while idle"}, 0, done);
            req = e.req;
            cycles = 0;
            do begin    // First edge accepts, done may follow at once
                @(posedge clk);
                #1;
                cycles++;
                if (!done) checkValue({e.name, " stall while busy"}, 1, stall);
            end while (!done);
            updateModel(e.req, expHit, expData, wbBase);
            checkValue({e.name, " cacheHit"}, expHit, cacheHit);
            checkValue({e.name, " one cycle hit"}, expHit, cycles == 1);
            if (e.req.rd) checkValue({e.name, " data"}, expData, dataOut);
            req.rd = 1'b0;
            req.wr = 1'b0;
            // Dirty victim now lives in main memory
            for (int w = 0; w < WordsPerLine && wbBase >= 0; w++) begin
                checkValue({e.name, " writeback"}, refMem[wbBase + w],
                           u_dut.u_mem.memArr[wbBase + w]);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: memSystem.f
src/memSysPkg.sv
src/cacheWay.sv
src/bankedMem.sv
src/cacheCtrl.sv
src/memSystem.sv
verification/clkGen.sv
verification/memSystemTb.sv

// File: Makefile
VERILATOR ?= verilator
SIM_TOP   ?= memSystemTb
FILELIST  ?= memSystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
